// File: mem_path_pkg.sv
`default_nettype none

package mem_path_pkg;

    // memory port geometry
    localparam int unsigned ADDR_W   = 32;
    localparam int unsigned BEAT_W   = 64;
    localparam int unsigned LINE_W   = 256;
    localparam int unsigned BEATS    = LINE_W / BEAT_W;
    // byte offset inside one line
    localparam int unsigned OFFSET_W = 5;

    typedef logic [ADDR_W-1:0]         addr_t;
    typedef logic [BEAT_W-1:0]         beat_t;
    typedef logic [LINE_W-1:0]         line_t;
    typedef logic [$clog2(BEATS)-1:0]  beat_idx_t;

    // which requester owns the memory path
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_INST,
        ARB_DATA
    } arb_state_e;

    // burst sequencing
    typedef enum logic [2:0] {
        BURST_IDLE,
        BURST_RD_REQ,
        BURST_RD_DATA,
        BURST_WR,
        BURST_DONE
    } burst_state_e;

endpackage : mem_path_pkg

`default_nettype wire

// File: line_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface line_req_if
    import mem_path_pkg::*;
();

    // request side, held until resp
    logic  read;
    logic  write;
    addr_t addr;
    line_t wdata;

    // response side, rdata valid with resp
    logic  resp;
    line_t rdata;

    modport arb (
        output read,
        output write,
        output addr,
        output wdata,
        input  resp,
        input  rdata
    );

    modport ctrl (
        input  read,
        input  write,
        input  addr,
        input  wdata,
        output resp,
        output rdata
    );

endinterface : line_req_if

`default_nettype wire

// File: beat_if.sv
`timescale 1ns/1ps
`default_nettype none

interface beat_if
    import mem_path_pkg::*;
();

    // controls from the burst controller
    logic  load_line;
    logic  shift_beat;
    logic  capture_beat;
    line_t wdata;

    // line register contents, beat 0 in the low bits
    line_t line_out;
    beat_t cur_beat;

    modport ctrl (
        output load_line,
        output shift_beat,
        output capture_beat,
        output wdata,
        input  line_out,
        input  cur_beat
    );

    modport buffer (
        input  load_line,
        input  shift_beat,
        input  capture_beat,
        input  wdata,
        output line_out,
        output cur_beat
    );

endinterface : beat_if

`default_nettype wire

// File: line_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module line_arbiter
    import mem_path_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    // instruction line requester
    input  logic  inst_read,
    input  addr_t inst_addr,
    output logic  inst_resp,
    output line_t inst_rdata,

    // data line requester
    input  logic  data_read,
    input  logic  data_write,
    input  addr_t data_addr,
    input  line_t data_wdata,
    output logic  data_resp,
    output line_t data_rdata,

    // shared line path toward the burst controller
    line_req_if.arb req
);

    arb_state_e state_q;
    arb_state_e state_d;

    logic inst_granted;
    logic data_granted;

    assign inst_granted = (state_q == ARB_INST);
    assign data_granted = (state_q == ARB_DATA);

    // data side wins a tie, grant held until the line comes back
    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: begin
                if (data_read || data_write) begin
                    state_d = ARB_DATA;
                end else if (inst_read) begin
                    state_d = ARB_INST;
                end
            end
            ARB_INST, ARB_DATA: begin
                if (req.resp) begin
                    state_d = ARB_IDLE;
                end
            end
            default: begin
                state_d = ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ARB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // steer the owner onto the shared path
    always_comb begin
        req.read  = 1'b0;
        req.write = 1'b0;
        req.addr  = '0;
        req.wdata = '0;
        if (data_granted) begin
            req.read  = data_read;
            req.write = data_write;
            req.addr  = data_addr;
            req.wdata = data_wdata;
        end else if (inst_granted) begin
            // instruction side never writes
            req.read  = inst_read;
            req.addr  = inst_addr;
        end
    end

    // response goes back only to the owner
    assign inst_resp  = inst_granted && req.resp;
    assign data_resp  = data_granted && req.resp;
    assign inst_rdata = inst_granted ? req.rdata : '0;
    assign data_rdata = data_granted ? req.rdata : '0;

endmodule : line_arbiter

`default_nettype wire

// File: burst_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module burst_ctrl
    import mem_path_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    // granted line request
    line_req_if.ctrl req,

    // beat buffer control
    beat_if.ctrl     beats,

    // memory side
    input  logic  bmem_ready,
    input  logic  bmem_rvalid,
    output addr_t bmem_addr,
    output logic  bmem_read,
    output logic  bmem_write
);

    localparam beat_idx_t LAST_BEAT = beat_idx_t'(BEATS - 1);

    burst_state_e state_q;
    burst_state_e state_d;
    beat_idx_t    beat_cnt_q;
    addr_t        addr_q;

    logic start;
    logic last_beat;
    logic beat_done;

    // a transfer starts only with the memory ready
    assign start     = (state_q == BURST_IDLE) && (req.read || req.write) && bmem_ready;
    assign last_beat = (beat_cnt_q == LAST_BEAT);

    // read strobe and first write beat wait for ready
    assign bmem_read  = (state_q == BURST_RD_REQ) && bmem_ready;
    assign bmem_write = (state_q == BURST_WR) && ((beat_cnt_q != '0) || bmem_ready);
    assign bmem_addr  = addr_q;

    assign beats.load_line    = start && req.write;
    assign beats.shift_beat   = bmem_write;
    assign beats.capture_beat = (state_q == BURST_RD_DATA) && bmem_rvalid;
    assign beats.wdata        = req.wdata;

    // one beat moved this cycle, either direction
    assign beat_done = beats.shift_beat || beats.capture_beat;

    assign req.resp  = (state_q == BURST_DONE);
    assign req.rdata = beats.line_out;

    always_comb begin
        state_d = state_q;
        case (state_q)
            BURST_IDLE: begin
                if (start) begin
                    state_d = req.write ? BURST_WR : BURST_RD_REQ;
                end
            end
            BURST_RD_REQ: begin
                if (bmem_ready) begin
                    state_d = BURST_RD_DATA;
                end
            end
            BURST_RD_DATA: begin
                // beats may arrive with gaps
                if (bmem_rvalid && last_beat) begin
                    state_d = BURST_DONE;
                end
            end
            BURST_WR: begin
                if (bmem_write && last_beat) begin
                    state_d = BURST_DONE;
                end
            end
            BURST_DONE: begin
                state_d = BURST_IDLE;
            end
            default: begin
                state_d = BURST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= BURST_IDLE;
            beat_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            // wraps back to zero after the fourth beat
            if (beat_done) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
            end
        end
    end

    // line-aligned address for the whole burst
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= {req.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        end
    end

endmodule : burst_ctrl

`default_nettype wire

// File: beat_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module beat_buffer
    import mem_path_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    // controls and line data from the burst controller
    beat_if.buffer beats,

    // memory beat data
    input  beat_t bmem_rdata,
    output beat_t bmem_wdata
);

    line_t line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            line_q <= '0;
        end else if (beats.load_line) begin
            line_q <= beats.wdata;
        end else if (beats.capture_beat) begin
            // new beat enters at the top, earlier beats move down
            line_q <= {bmem_rdata, line_q[LINE_W-1:BEAT_W]};
        end else if (beats.shift_beat) begin
            // rotate so the next write beat sits at the bottom
            line_q <= {line_q[BEAT_W-1:0], line_q[LINE_W-1:BEAT_W]};
        end
    end

    assign beats.line_out = line_q;
    assign beats.cur_beat = line_q[BEAT_W-1:0];

    // beat 0 of what is left always faces memory
    assign bmem_wdata = beats.cur_beat;

endmodule : beat_buffer

`default_nettype wire

// File: mem_path_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_path_top
    import mem_path_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    // instruction line requester
    input  logic  inst_read,
    input  addr_t inst_addr,
    output logic  inst_resp,
    output line_t inst_rdata,

    // data line requester
    input  logic  data_read,
    input  logic  data_write,
    input  addr_t data_addr,
    input  line_t data_wdata,
    output logic  data_resp,
    output line_t data_rdata,

    // burst memory port
    output addr_t bmem_addr,
    output logic  bmem_read,
    output logic  bmem_write,
    output beat_t bmem_wdata,
    input  logic  bmem_ready,
    input  beat_t bmem_rdata,
    input  logic  bmem_rvalid
);

    line_req_if req_bus ();
    beat_if     beat_bus ();

    line_arbiter u_line_arbiter (
        .clk        (clk),
        .rst        (rst),
        .inst_read  (inst_read),
        .inst_addr  (inst_addr),
        .inst_resp  (inst_resp),
        .inst_rdata (inst_rdata),
        .data_read  (data_read),
        .data_write (data_write),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_resp  (data_resp),
        .data_rdata (data_rdata),
        .req        (req_bus)
    );

    burst_ctrl u_burst_ctrl (
        .clk         (clk),
        .rst         (rst),
        .req         (req_bus),
        .beats       (beat_bus),
        .bmem_ready  (bmem_ready),
        .bmem_rvalid (bmem_rvalid),
        .bmem_addr   (bmem_addr),
        .bmem_read   (bmem_read),
        .bmem_write  (bmem_write)
    );

    beat_buffer u_beat_buffer (
        .clk        (clk),
        .rst        (rst),
        .beats      (beat_bus),
        .bmem_rdata (bmem_rdata),
        .bmem_wdata (bmem_wdata)
    );

endmodule : mem_path_top

`default_nettype wire

// File: mem_path_props.sv
`timescale 1ns/1ps
`default_nettype none

module mem_path_props
    import mem_path_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  bmem_read,
    input logic  bmem_write,
    input logic  bmem_ready,
    input addr_t bmem_addr,
    input logic  resp
);

    // read by the testbench at the end of the run
    int fail_count = 0;

    // read strobe is a single cycle
    read_one_cycle: assert property (@(posedge clk) disable iff (rst)
        bmem_read |=> !bmem_read)
        else begin
            fail_count++;
            $error("bmem_read held longer than one cycle");
        end

    // write burst is exactly four cycles
    write_four_cycles: assert property (@(posedge clk) disable iff (rst)
        $rose(bmem_write) |-> bmem_write [*4] ##1 !bmem_write)
        else begin
            fail_count++;
            $error("bmem_write burst is not four cycles long");
        end

    // no strobe toward a busy memory
    read_needs_ready: assert property (@(posedge clk) disable iff (rst)
        bmem_read |-> bmem_ready)
        else begin
            fail_count++;
            $error("bmem_read issued while bmem_ready low");
        end

    write_needs_ready: assert property (@(posedge clk) disable iff (rst)
        $rose(bmem_write) |-> bmem_ready)
        else begin
            fail_count++;
            $error("first write beat issued while bmem_ready low");
        end

    addr_aligned: assert property (@(posedge clk) disable iff (rst)
        (bmem_read || bmem_write) |-> (bmem_addr[OFFSET_W-1:0] == '0))
        else begin
            fail_count++;
            $error("bmem_addr not line aligned during a strobe");
        end

    resp_one_cycle: assert property (@(posedge clk) disable iff (rst)
        resp |=> !resp)
        else begin
            fail_count++;
            $error("line response held longer than one cycle");
        end

    // outputs quiet right after reset
    quiet_after_reset: assert property (@(posedge clk)
        rst |=> (!bmem_read && !bmem_write && !resp))
        else begin
            fail_count++;
            $error("strobes or response active after reset");
        end

endmodule : mem_path_props

bind burst_ctrl mem_path_props u_props (
    .clk        (clk),
    .rst        (rst),
    .bmem_read  (bmem_read),
    .bmem_write (bmem_write),
    .bmem_ready (bmem_ready),
    .bmem_addr  (bmem_addr),
    .resp       (req.resp)
);

`default_nettype wire

// File: tb_mem_path.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_path;
    import mem_path_pkg::*;

    localparam int N_XFERS = 16;
    localparam int CLK_PERIOD = 20;

    logic  clk;
    logic  rst;
    logic  inst_read;
    addr_t inst_addr;
    logic  inst_resp;
    line_t inst_rdata;
    logic  data_read;
    logic  data_write;
    addr_t data_addr;
    line_t data_wdata;
    logic  data_resp;
    line_t data_rdata;
    addr_t bmem_addr;
    logic  bmem_read;
    logic  bmem_write;
    beat_t bmem_wdata;
    logic  bmem_ready;
    beat_t bmem_rdata;
    logic  bmem_rvalid;

    int    seed = 32'h02a4_17bd;
    line_t mem [addr_t];
    logic  stall;
    int    errors;
    int    tests_passed;
    int    tests_failed;

    // write beat collection
    line_t wr_line;
    int    wr_idx;

    mem_path_top dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // line at an aligned address, filled from the seed on first touch
    function automatic line_t get_line(input addr_t a);
        line_t l;
        if (!mem.exists(a)) begin
            for (int i = 0; i < LINE_W / 32; i++) begin
                l[i*32 +: 32] = $random(seed);
            end
            mem[a] = l;
        end
        return mem[a];
    endfunction

    function automatic addr_t align(input addr_t a);
        return a & ~addr_t'((LINE_W / 8) - 1);
    endfunction

    always @(negedge clk) begin
        if (stall || rst) begin
            bmem_ready <= 1'b0;
        end else begin
            bmem_ready <= (({$random(seed)} % 4) != 0);
        end
    end

    // read beats come back in order, with random delay and gaps
    initial begin
        addr_t a;
        line_t l;
        int    gap;
        forever begin
            @(posedge clk);
            if (bmem_read) begin
                a = bmem_addr;
                l = get_line(a);
                for (int b = 0; b < BEATS; b++) begin
                    gap = (b == 0) ? ({$random(seed)} % 5) : ({$random(seed)} % 3);
                    repeat (gap) begin
                        @(negedge clk);
                        bmem_rvalid = 1'b0;
                    end
                    @(negedge clk);
                    bmem_rvalid = 1'b1;
                    bmem_rdata  = l[b*BEAT_W +: BEAT_W];
                end
                @(negedge clk);
                bmem_rvalid = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            wr_idx = 0;
        end else if (bmem_write) begin
            wr_line[wr_idx*BEAT_W +: BEAT_W] = bmem_wdata;
            wr_idx++;
            if (wr_idx == BEATS) begin
                mem[bmem_addr] = wr_line;
                wr_idx = 0;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            assert (!(inst_resp && data_resp))
            else begin
                $display("MISMATCH at %0t: inst_resp and data_resp high together", $time);
                errors++;
            end
        end
    end

    task automatic check_line(input string what, input line_t got, input line_t exp);
        assert (got === exp)
        else begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic inst_fetch(input addr_t a, output line_t l, output time t);
        @(negedge clk);
        inst_read = 1'b1;
        inst_addr = a;
        @(posedge clk);
        while (!inst_resp) @(posedge clk);
        l = inst_rdata;
        t = $time;
        @(negedge clk);
        inst_read = 1'b0;
    endtask

    task automatic data_access(input logic wr, input addr_t a, input line_t wd,
                               output line_t l, output time t);
        @(negedge clk);
        data_read  = !wr;
        data_write = wr;
        data_addr  = a;
        data_wdata = wd;
        @(posedge clk);
        while (!data_resp) @(posedge clk);
        l = data_rdata;
        t = $time;
        @(negedge clk);
        data_read  = 1'b0;
        data_write = 1'b0;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed", name);
        end
    endtask

    // watchdog sized from the number of transfers
    initial begin
        #(40 * N_XFERS * CLK_PERIOD);
        $display("timeout: transfers did not complete in time");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        addr_t a;
        line_t got;
        line_t got2;
        line_t wd;
        time   t_inst;
        time   t_data;
        int    e0;

        clk = 1'b0;
        rst = 1'b1;
        inst_read = 1'b0;
        inst_addr = '0;
        data_read = 1'b0;
        data_write = 1'b0;
        data_addr = '0;
        data_wdata = '0;
        bmem_ready = 1'b0;
        bmem_rdata = '0;
        bmem_rvalid = 1'b0;
        stall = 1'b0;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            a = $random(seed);
            inst_fetch(a, got, t_inst);
            check_line("inst read", got, get_line(align(a)));
        end
        finish_test("inst_read", e0);

        e0 = errors;
        for (int i = 0; i < 3; i++) begin
            a = $random(seed);
            for (int k = 0; k < LINE_W / 32; k++) begin
                wd[k*32 +: 32] = $random(seed);
            end
            data_access(1'b1, a, wd, got, t_data);
            check_line("memory after write", get_line(align(a)), wd);
            data_access(1'b0, a, '0, got, t_data);
            check_line("data read back", got, wd);
        end
        finish_test("write_read", e0);

        e0 = errors;
        for (int i = 0; i < 2; i++) begin
            a = $random(seed);
            fork
                inst_fetch(a, got, t_inst);
                data_access(1'b0, a + 32'h100, '0, got2, t_data);
            join
            check_line("arb inst line", got, get_line(align(a)));
            check_line("arb data line", got2, get_line(align(a + 32'h100)));
            assert (t_data < t_inst)
            else begin
                $display("MISMATCH at %0t: inst response came before data", $time);
                errors++;
            end
        end
        finish_test("arbitration", e0);

        // memory held busy while the requests wait
        e0 = errors;
        a = $random(seed);
        stall = 1'b1;
        fork
            inst_fetch(a, got, t_inst);
            begin
                repeat (10) @(negedge clk);
                stall = 1'b0;
            end
        join
        check_line("stalled inst read", got, get_line(align(a)));
        stall = 1'b1;
        for (int k = 0; k < LINE_W / 32; k++) begin
            wd[k*32 +: 32] = $random(seed);
        end
        fork
            data_access(1'b1, a, wd, got, t_data);
            begin
                repeat (10) @(negedge clk);
                stall = 1'b0;
            end
        join
        check_line("stalled write", get_line(align(a)), wd);
        finish_test("back_pressure", e0);

        repeat (4) @(posedge clk);
        errors += dut.u_burst_ctrl.u_props.fail_count;
        $display("tests passed %0d failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : tb_mem_path

`default_nettype wire

// File: compile.f
mem_path_pkg.sv
line_req_if.sv
beat_if.sv
line_arbiter.sv
burst_ctrl.sv
beat_buffer.sv
mem_path_top.sv
mem_path_props.sv
tb_mem_path.sv

// File: Bender.yml
package:
  name: mem_path

sources:
  - mem_path_pkg.sv
  - line_req_if.sv
  - beat_if.sv
  - line_arbiter.sv
  - burst_ctrl.sv
  - beat_buffer.sv
  - mem_path_top.sv
  - target: simulation
    files:
      - mem_path_props.sv
      - tb_mem_path.sv
